/* verilog/cdb_pkg.sv */
package cdb_pkg;

	//////////////////////////////////////////////////////////////////////
	// widths
	//////////////////////////////////////////////////////////////////////

	localparam int data_w = 32;
	// 16 result tags
	localparam int tag_w = 4;

	//////////////////////////////////////////////////////////////////////
	// latencies, counted in rising edges including the accepting one
	//////////////////////////////////////////////////////////////////////

	localparam int lat_alu = 2;
	localparam int lat_mul = 4;

	// the longest unit sets the reservation depth
	localparam int rsv_depth = lat_mul;

	//////////////////////////////////////////////////////////////////////
	// encodings
	//////////////////////////////////////////////////////////////////////

	typedef enum logic[1:0] {
		OP_ADD = 2'b00,
		OP_SUB = 2'b01,
		OP_MUL = 2'b10
	} op_t;

	// owner of a reserved bus slot
	typedef enum logic {
		SRC_ALU = 1'b0,
		SRC_MUL = 1'b1
	} src_t;

endpackage

/* verilog/cdb_sched.sv */
module cdb_sched (
	input logic clk,
	input logic rst_n,
	input logic issue_valid,
	input cdb_pkg::op_t issue_op,
	input logic[cdb_pkg::tag_w-1:0] issue_tag,
	input logic[cdb_pkg::data_w-1:0] issue_a,
	input logic[cdb_pkg::data_w-1:0] issue_b,
	input logic in_valid,
	input logic[cdb_pkg::tag_w-1:0] in_tag,
	input logic[cdb_pkg::data_w-1:0] in_data,
	input logic[cdb_pkg::data_w-1:0] alu_result,
	input logic[cdb_pkg::tag_w-1:0] alu_tag_out,
	input logic[cdb_pkg::data_w-1:0] mul_result,
	input logic[cdb_pkg::tag_w-1:0] mul_tag_out,
	output logic issue_ready,
	output logic in_ready,
	output logic alu_start,
	output logic alu_sub,
	output logic mul_start,
	output logic[cdb_pkg::tag_w-1:0] unit_tag,
	output logic[cdb_pkg::data_w-1:0] unit_a,
	output logic[cdb_pkg::data_w-1:0] unit_b,
	output logic cdb_valid,
	output logic[cdb_pkg::tag_w-1:0] cdb_tag,
	output logic[cdb_pkg::data_w-1:0] cdb_data
);
	import cdb_pkg::*;

	//////////////////////////////////////////////////////////////////////
	// reservation slots
	//////////////////////////////////////////////////////////////////////

	// slot k holds the result due k cycles from now, slot 0 owns the bus
	logic[rsv_depth-1:0] rsv_valid;
	logic[rsv_depth-1:0] rsv_valid_nxt;
	src_t rsv_src [rsv_depth];
	src_t rsv_src_nxt [rsv_depth];

	logic is_mul;
	logic in_accept;

	//////////////////////////////////////////////////////////////////////
	// issue decode and acceptance
	//////////////////////////////////////////////////////////////////////

	assign is_mul = issue_op == OP_MUL;

	// mul lands past every slot in use, add/sub needs its slot free
	assign issue_ready = is_mul || !rsv_valid[lat_alu];

	assign alu_start = issue_valid && issue_ready && !is_mul;
	assign alu_sub   = issue_op == OP_SUB;
	assign mul_start = issue_valid && issue_ready && is_mul;

	// both units read the same operand lines
	assign unit_tag = issue_tag;
	assign unit_a   = issue_a;
	assign unit_b   = issue_b;

	//////////////////////////////////////////////////////////////////////
	// slot shift and marking
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		for (int k = 0; k < rsv_depth - 1; k++) begin
			rsv_valid_nxt[k] = rsv_valid[k+1];
			rsv_src_nxt[k]   = rsv_src[k+1];
		end
		rsv_valid_nxt[rsv_depth-1] = 1'b0;
		rsv_src_nxt[rsv_depth-1]   = SRC_MUL;

		// new entry sits one below its latency after this edge
		if (alu_start) begin
			rsv_valid_nxt[lat_alu-1] = 1'b1;
			rsv_src_nxt[lat_alu-1]   = SRC_ALU;
		end
		if (mul_start) begin
			rsv_valid_nxt[lat_mul-1] = 1'b1;
			rsv_src_nxt[lat_mul-1]   = SRC_MUL;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rsv_valid <= '0;
		end else begin
			rsv_valid <= rsv_valid_nxt;
		end
	end

	always_ff @(posedge clk) begin
		rsv_src <= rsv_src_nxt;
	end

	//////////////////////////////////////////////////////////////////////
	// bus output
	//////////////////////////////////////////////////////////////////////

	// input path fills cycles no unit owns
	assign in_ready  = !rsv_valid[0];
	assign in_accept = in_valid && in_ready;

	assign cdb_valid = rsv_valid[0] || in_accept;

	always_comb begin
		if (!rsv_valid[0]) begin
			cdb_tag  = in_tag;
			cdb_data = in_data;
		end else if (rsv_src[0] == SRC_ALU) begin
			cdb_tag  = alu_tag_out;
			cdb_data = alu_result;
		end else begin
			cdb_tag  = mul_tag_out;
			cdb_data = mul_result;
		end
	end

endmodule

/* verilog/alu_pipe.sv */
module alu_pipe (
	input logic clk,
	input logic rst_n,
	input logic alu_start,
	input logic alu_sub,
	input logic[cdb_pkg::tag_w-1:0] unit_tag,
	input logic[cdb_pkg::data_w-1:0] unit_a,
	input logic[cdb_pkg::data_w-1:0] unit_b,
	output logic[cdb_pkg::data_w-1:0] alu_result,
	output logic[cdb_pkg::tag_w-1:0] alu_tag_out
);
	import cdb_pkg::*;

	logic s1_vld;
	logic[data_w-1:0] s1_result;
	logic[tag_w-1:0] s1_tag;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			s1_vld <= 1'b0;
		end else begin
			s1_vld <= alu_start;
		end
	end

	// stage 1, wraps at 32 bits
	always_ff @(posedge clk) begin
		if (alu_start) begin
			if (alu_sub) begin
				s1_result <= unit_a - unit_b;
			end else begin
				s1_result <= unit_a + unit_b;
			end
			s1_tag <= unit_tag;
		end
	end

	// stage 2 drives the bus candidate
	always_ff @(posedge clk) begin
		if (s1_vld) begin
			alu_result  <= s1_result;
			alu_tag_out <= s1_tag;
		end
	end

endmodule

/* verilog/mul_pipe.sv */
module mul_pipe (
	input logic clk,
	input logic rst_n,
	input logic mul_start,
	input logic[cdb_pkg::tag_w-1:0] unit_tag,
	input logic[cdb_pkg::data_w-1:0] unit_a,
	input logic[cdb_pkg::data_w-1:0] unit_b,
	output logic[cdb_pkg::data_w-1:0] mul_result,
	output logic[cdb_pkg::tag_w-1:0] mul_tag_out
);
	import cdb_pkg::*;

	// halves of the operands
	logic[data_w/2-1:0] a_lo;
	logic[data_w/2-1:0] a_hi;
	logic[data_w/2-1:0] b_lo;
	logic[data_w/2-1:0] b_hi;

	logic[3:1] vld;

	logic[data_w-1:0] s1_ll;
	logic[data_w/2-1:0] s1_hl;
	logic[data_w/2-1:0] s1_lh;
	logic[tag_w-1:0] s1_tag;

	logic[data_w-1:0] s2_ll;
	logic[data_w/2-1:0] s2_cross;
	logic[tag_w-1:0] s2_tag;

	logic[data_w-1:0] s3_prod;
	logic[tag_w-1:0] s3_tag;

	assign a_lo = unit_a[data_w/2-1:0];
	assign a_hi = unit_a[data_w-1:data_w/2];
	assign b_lo = unit_b[data_w/2-1:0];
	assign b_hi = unit_b[data_w-1:data_w/2];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			vld <= '0;
		end else begin
			vld <= {vld[2:1], mul_start};
		end
	end

	// stage 1, partial products; the high cross terms only need low halves
	always_ff @(posedge clk) begin
		if (mul_start) begin
			s1_ll  <= a_lo * b_lo;
			s1_hl  <= a_hi * b_lo;
			s1_lh  <= a_lo * b_hi;
			s1_tag <= unit_tag;
		end
	end

	// stage 2, sum the cross terms
	always_ff @(posedge clk) begin
		if (vld[1]) begin
			s2_ll    <= s1_ll;
			s2_cross <= s1_hl + s1_lh;
			s2_tag   <= s1_tag;
		end
	end

	// stage 3, low product bits
	always_ff @(posedge clk) begin
		if (vld[2]) begin
			s3_prod <= s2_ll + {s2_cross, {(data_w/2){1'b0}}};
			s3_tag  <= s2_tag;
		end
	end

	// stage 4
	always_ff @(posedge clk) begin
		if (vld[3]) begin
			mul_result  <= s3_prod;
			mul_tag_out <= s3_tag;
		end
	end

endmodule

/* verilog/cdb_top.sv */
module cdb_top (
	input logic clk,
	input logic rst_n,
	input logic issue_valid,
	input cdb_pkg::op_t issue_op,
	input logic[cdb_pkg::tag_w-1:0] issue_tag,
	input logic[cdb_pkg::data_w-1:0] issue_a,
	input logic[cdb_pkg::data_w-1:0] issue_b,
	input logic in_valid,
	input logic[cdb_pkg::tag_w-1:0] in_tag,
	input logic[cdb_pkg::data_w-1:0] in_data,
	output logic issue_ready,
	output logic in_ready,
	output logic cdb_valid,
	output logic[cdb_pkg::tag_w-1:0] cdb_tag,
	output logic[cdb_pkg::data_w-1:0] cdb_data
);
	import cdb_pkg::*;

	// scheduler to units
	logic alu_start;
	logic alu_sub;
	logic mul_start;
	logic[tag_w-1:0] unit_tag;
	logic[data_w-1:0] unit_a;
	logic[data_w-1:0] unit_b;

	// unit results
	logic[data_w-1:0] alu_result;
	logic[tag_w-1:0] alu_tag_out;
	logic[data_w-1:0] mul_result;
	logic[tag_w-1:0] mul_tag_out;

	cdb_sched cdb_sched (
		.clk,
		.rst_n,
		.issue_valid,
		.issue_op,
		.issue_tag,
		.issue_a,
		.issue_b,
		.in_valid,
		.in_tag,
		.in_data,
		.alu_result,
		.alu_tag_out,
		.mul_result,
		.mul_tag_out,
		.issue_ready,
		.in_ready,
		.alu_start,
		.alu_sub,
		.mul_start,
		.unit_tag,
		.unit_a,
		.unit_b,
		.cdb_valid,
		.cdb_tag,
		.cdb_data
	);

	alu_pipe alu_pipe (
		.clk,
		.rst_n,
		.alu_start,
		.alu_sub,
		.unit_tag,
		.unit_a,
		.unit_b,
		.alu_result,
		.alu_tag_out
	);

	mul_pipe mul_pipe (
		.clk,
		.rst_n,
		.mul_start,
		.unit_tag,
		.unit_a,
		.unit_b,
		.mul_result,
		.mul_tag_out
	);

endmodule

/* verification/tb_clock.sv */
module tb_clock (
	output logic clk,
	output logic rst_n
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// release away from the rising edge
	initial begin
		rst_n = 1'b0;
		repeat (16) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
	end

endmodule

/* verification/cdb_sva.sv */
module cdb_sva (
	input logic clk,
	input logic rst_n,
	input logic issue_valid,
	input cdb_pkg::op_t issue_op,
	input logic issue_ready,
	input logic in_valid,
	input logic in_ready,
	input logic alu_start,
	input logic mul_start,
	input logic cdb_valid,
	input logic[cdb_pkg::rsv_depth-1:0] rsv_valid,
	input cdb_pkg::src_t slot0_src
);
	timeunit 1ns;
	timeprecision 100ps;
	import cdb_pkg::*;

	// some request has reached the bus path since reset
	logic seen_accept;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			seen_accept <= 1'b0;
		end else if (alu_start || mul_start || (in_valid && in_ready)) begin
			seen_accept <= 1'b1;
		end
	end

	// a mul is taken at once and owns the bus lat_mul edges later
	mul_never_refused: assert property (@(posedge clk) disable iff (!rst_n)
		issue_valid && issue_op == OP_MUL |->
			issue_ready ##lat_mul (rsv_valid[0] && slot0_src == SRC_MUL))
		else $error("MUL issue refused or its bus slot not owned by the multiplier");

	// the alu slot keeps the input path off the bus
	input_yields_to_unit: assert property (@(posedge clk) disable iff (!rst_n)
		alu_start |-> ##lat_alu (rsv_valid[0] && slot0_src == SRC_ALU && !in_ready))
		else $error("ALU bus slot not reserved or in_ready high while it is");

	no_spurious_bus: assert property (@(posedge clk) disable iff (!rst_n)
		cdb_valid |-> seen_accept || (in_valid && in_ready))
		else $error("cdb_valid high before any accepted request");

endmodule

bind cdb_sched cdb_sva cdb_sva (
	.clk,
	.rst_n,
	.issue_valid,
	.issue_op,
	.issue_ready,
	.in_valid,
	.in_ready,
	.alu_start,
	.mul_start,
	.cdb_valid,
	.rsv_valid,
	.slot0_src(rsv_src[0])
);

/* verification/tb_cdb.sv */
module tb_cdb;
	timeunit 1ns;
	timeprecision 100ps;
	import cdb_pkg::*;

	logic clk;
	logic rst_n;
	logic issue_valid;
	op_t issue_op;
	logic[tag_w-1:0] issue_tag;
	logic[data_w-1:0] issue_a;
	logic[data_w-1:0] issue_b;
	logic in_valid;
	logic[tag_w-1:0] in_tag;
	logic[data_w-1:0] in_data;
	logic issue_ready;
	logic in_ready;
	logic cdb_valid;
	logic[tag_w-1:0] cdb_tag;
	logic[data_w-1:0] cdb_data;

	// request of the current vector line
	logic req_iv;
	op_t req_op;
	logic[tag_w-1:0] req_tag;
	logic[data_w-1:0] req_a;
	logic[data_w-1:0] req_b;
	logic req_inv;
	logic[tag_w-1:0] req_itag;
	logic[data_w-1:0] req_idata;

	// scoreboard, one entry per tag
	logic pending [2**tag_w];
	logic[data_w-1:0] exp_data [2**tag_w];
	int exp_cycle [2**tag_w];

	int cycle;
	int seed = 25;
	int cur_test;
	int tests;
	int checks;
	int errors;
	int test_errors;
	int fd;
	logic released;

	tb_clock tb_clock (.clk, .rst_n);

	cdb_top UUT (
		.clk,
		.rst_n,
		.issue_valid,
		.issue_op,
		.issue_tag,
		.issue_a,
		.issue_b,
		.in_valid,
		.in_tag,
		.in_data,
		.issue_ready,
		.in_ready,
		.cdb_valid,
		.cdb_tag,
		.cdb_data
	);

	task automatic count_error();
		errors++;
		test_errors++;
	endtask

	task automatic compare(input string name, input logic[31:0] expected, input logic[31:0] got);
		checks++;
		if (got !== expected) begin
			$display("Mismatch %s expected %h got %h", name, expected, got);
			count_error();
		end
	endtask

	function automatic logic[data_w-1:0] op_result(op_t op, logic[data_w-1:0] a,
			logic[data_w-1:0] b);
		case (op)
			OP_ADD: return a + b;
			OP_SUB: return a - b;
			default: return a * b;
		endcase
	endfunction

	// some outstanding result is due in that cycle
	function automatic logic slot_taken(int cyc);
		for (int t = 0; t < 2**tag_w; t++) begin
			if (pending[t] && exp_cycle[t] == cyc) begin
				return 1'b1;
			end
		end
		return 1'b0;
	endfunction

	function automatic logic any_pending();
		for (int t = 0; t < 2**tag_w; t++) begin
			if (pending[t]) begin
				return 1'b1;
			end
		end
		return 1'b0;
	endfunction

	task automatic expect_result(input logic[tag_w-1:0] tag, input logic[data_w-1:0] data,
			input int due);
		if (pending[tag]) begin
			$display("test %0d: tag %h accepted while still outstanding", cur_test, tag);
			count_error();
		end
		pending[tag] = 1'b1;
		exp_data[tag] = data;
		exp_cycle[tag] = due;
	endtask

	// one cycle, driven at the falling edge and sampled once settled
	task automatic step(output logic iss_acc, output logic in_acc);
		int lat;
		@(negedge clk);
		issue_valid = req_iv;
		issue_op = req_op;
		issue_tag = req_tag;
		issue_a = req_a;
		issue_b = req_b;
		in_valid = req_inv;
		in_tag = req_itag;
		in_data = req_idata;
		cycle++;
		#1;
		if (req_iv) begin
			compare("issue_ready", 32'(req_op == OP_MUL || !slot_taken(cycle + lat_alu)),
				32'(issue_ready));
		end
		if (req_inv) begin
			compare("in_ready", 32'(!slot_taken(cycle)), 32'(in_ready));
		end
		iss_acc = req_iv && issue_ready;
		in_acc = req_inv && in_ready;
		lat = (req_op == OP_MUL) ? lat_mul : lat_alu;
		if (iss_acc) begin
			expect_result(req_tag, op_result(req_op, req_a, req_b), cycle + lat);
		end
		if (in_acc) begin
			expect_result(req_itag, req_idata, cycle);
		end
		if (cdb_valid) begin
			if (!pending[cdb_tag]) begin
				$display("test %0d: cdb_valid high with tag %h and no outstanding result",
					cur_test, cdb_tag);
				count_error();
			end else begin
				compare("cdb_data", exp_data[cdb_tag], cdb_data);
				compare("cdb_cycle", 32'(exp_cycle[cdb_tag]), 32'(cycle));
				pending[cdb_tag] = 1'b0;
			end
		end
	endtask

	task automatic finish_test();
		logic iss_acc;
		logic in_acc;
		int n;
		n = 0;
		req_iv = 1'b0;
		req_inv = 1'b0;
		while (any_pending() && n < 20) begin
			step(iss_acc, in_acc);
			n++;
		end
		for (int t = 0; t < 2**tag_w; t++) begin
			if (pending[t]) begin
				$display("test %0d: result for tag %h never appeared on the bus", cur_test, t);
				count_error();
				pending[t] = 1'b0;
			end
		end
		tests++;
		$display("test %0d done, %0d errors", cur_test, test_errors);
	endtask

	task automatic wait_reset(output logic ok);
		int n;
		n = 0;
		while (rst_n !== 1'b1 && n < 40) begin
			@(negedge clk);
			#1;
			compare("cdb_valid", 32'd0, 32'(cdb_valid));
			n++;
		end
		ok = rst_n === 1'b1;
	endtask

	task automatic run_vectors();
		string line;
		int n;
		int test_no;
		int iv_i;
		int op_i;
		int inv_i;
		logic[31:0] tag_i;
		logic[31:0] a;
		logic[31:0] b;
		logic[31:0] itag_i;
		logic[31:0] idata;
		logic iss_acc;
		logic in_acc;
		int tries;
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			n = $sscanf(line, "%d %d %d %h %h %h %d %h %h", test_no, iv_i, op_i, tag_i, a, b,
				inv_i, itag_i, idata);
			if (n == 9) begin
				if (test_no != cur_test) begin
					if (cur_test != 0) begin
						finish_test();
					end
					cur_test = test_no;
					test_errors = 0;
				end
				// issue_valid 2 asks for random operands
				if (iv_i == 2) begin
					a = $random(seed);
					b = $random(seed);
				end
				req_iv = iv_i != 0;
				req_op = op_t'(op_i[1:0]);
				req_tag = tag_i[tag_w-1:0];
				req_a = a;
				req_b = b;
				req_inv = inv_i != 0;
				req_itag = itag_i[tag_w-1:0];
				req_idata = idata;
				tries = 0;
				do begin
					step(iss_acc, in_acc);
					if (iss_acc) begin
						req_iv = 1'b0;
					end
					if (in_acc) begin
						req_inv = 1'b0;
					end
					tries++;
				end while ((req_iv || req_inv) && tries < 20);
				if (req_iv || req_inv) begin
					$display("test %0d: request not accepted within 20 cycles", cur_test);
					count_error();
				end
			end
		end
		if (cur_test != 0) begin
			finish_test();
		end
	endtask

	initial begin
		issue_valid = 1'b0;
		issue_op = OP_ADD;
		issue_tag = '0;
		issue_a = '0;
		issue_b = '0;
		in_valid = 1'b0;
		in_tag = '0;
		in_data = '0;
		req_iv = 1'b0;
		req_op = OP_ADD;
		req_inv = 1'b0;
		for (int t = 0; t < 2**tag_w; t++) begin
			pending[t] = 1'b0;
		end
		wait_reset(released);
		fd = $fopen("verification/cdb_vectors.txt", "r");
		if (!released || fd == 0) begin
			$display("run aborted, reset never released or vector file not found");
			$display("CHECKS FAILED");
			$finish;
		end else begin
			run_vectors();
			$fclose(fd);
			$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
			if (errors == 0) begin
				$display("ALL CHECKS PASSED");
			end else begin
				$display("CHECKS FAILED");
			end
			$finish;
		end
	end

endmodule

/* verification/cdb_vectors.txt */
// test issue_valid op tag a b in_valid in_tag in_data
// issue_valid 2 draws a and b from $random, op 0 add 1 sub 2 mul
1 0 0 0 00000000 00000000 0 0 00000000
1 0 0 0 00000000 00000000 0 0 00000000
1 2 0 1 00000000 00000000 0 0 00000000
1 2 1 2 00000000 00000000 0 0 00000000
1 2 0 3 00000000 00000000 0 0 00000000
1 2 1 4 00000000 00000000 0 0 00000000
1 2 0 5 00000000 00000000 0 0 00000000
1 2 1 6 00000000 00000000 0 0 00000000
1 1 0 7 ffffffff 00000001 0 0 00000000
1 1 1 8 00000000 00000001 0 0 00000000
2 1 2 1 0000ffff 0000ffff 0 0 00000000
2 1 2 2 12345678 9abcdef0 0 0 00000000
2 1 2 3 ffffffff ffffffff 0 0 00000000
2 1 2 4 00010000 00010000 0 0 00000000
2 1 2 5 80000000 00000003 0 0 00000000
2 1 2 6 0000abcd 00001234 0 0 00000000
3 1 2 1 00000007 00000006 0 0 00000000
3 0 0 0 00000000 00000000 0 0 00000000
3 1 0 2 00000010 00000020 0 0 00000000
3 1 2 3 0000ffff 00010001 0 0 00000000
3 1 1 4 00000100 00000001 0 0 00000000
4 0 0 0 00000000 00000000 1 1 cafef00d
4 0 0 0 00000000 00000000 1 2 0badbeef
4 1 0 3 00000001 00000002 0 0 00000000
4 0 0 0 00000000 00000000 0 0 00000000
4 0 0 0 00000000 00000000 1 4 11112222
4 1 2 5 00000003 00000005 1 6 33334444
4 0 0 0 00000000 00000000 0 0 00000000
4 0 0 0 00000000 00000000 0 0 00000000
4 0 0 0 00000000 00000000 0 0 00000000
4 0 0 0 00000000 00000000 1 7 55556666
5 1 2 0 00000003 00000004 1 1 00000101
5 1 0 2 00000005 00000006 1 3 00000303
5 1 1 4 00000009 00000002 0 0 00000000
5 1 2 5 00001000 00001000 0 0 00000000
5 1 2 6 fffffffe 00000002 0 0 00000000
5 1 0 7 7fffffff 00000001 0 0 00000000
5 0 0 0 00000000 00000000 1 8 00000808
5 1 1 9 00000001 00000002 0 0 00000000
5 1 2 a 00000011 00000011 0 0 00000000
5 1 0 b 0000aaaa 00005555 0 0 00000000
5 0 0 0 00000000 00000000 1 c 00000c0c
5 1 2 d 00000100 00000100 0 0 00000000
5 1 1 e 00000000 ffffffff 0 0 00000000
5 0 0 0 00000000 00000000 1 f 00000f0f

/* verilog.f */
verilog/cdb_pkg.sv
verilog/cdb_sched.sv
verilog/alu_pipe.sv
verilog/mul_pipe.sv
verilog/cdb_top.sv
verification/tb_clock.sv
verification/cdb_sva.sv
verification/tb_cdb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_cdb -f verilog.f

if ! ./obj_dir/Vtb_cdb > sim.log 2>&1; then
	cat sim.log
	echo "simulation exited with an error"
	exit 1
fi
cat sim.log

if grep -qx "CHECKS FAILED" sim.log; then
	exit 1
fi
if ! grep -qx "ALL CHECKS PASSED" sim.log; then
	echo "simulation ended without a result"
	exit 1
fi
